//--- logic/sys_info_pkg.sv
package sys_info_pkg;

    // host side
    typedef logic [7:0] status_byte_t;   // one byte as seen by the host
    typedef logic [7:0] status_addr_t;

    // bcd values
    typedef logic [3:0]  bcd_digit_t;
    typedef logic [19:0] frame_bcd_t;    // five digits, msd in [19:16]
    typedef logic [7:0]  rate_bcd_t;     // two digits, samples per ms

    // sdram banks
    localparam int NUM_BANKS = 4;
    typedef logic [NUM_BANKS-1:0] bank_rdy_t;   // one ready strobe per bank

    // status address fields
    localparam int ADDR_GRP_HI = 7;      // group select
    localparam int ADDR_GRP_LO = 6;
    localparam int ADDR_SUB_HI = 5;      // item within group 1 and 3
    localparam int ADDR_SUB_LO = 4;
    localparam int ADDR_SEL_HI = 3;      // second level in group 1
    localparam int ADDR_SEL_LO = 2;
    localparam int ADDR_IDX_HI = 1;      // byte or bank index
    localparam int ADDR_IDX_LO = 0;

    // group codes
    localparam logic [1:0] GRP_FRAME = 2'd0;
    localparam logic [1:0] GRP_SYS   = 2'd1;    // sound, rate, download, dips
    localparam logic [1:0] GRP_BANK  = 2'd2;
    localparam logic [1:0] GRP_IO    = 2'd3;    // core mode, mouse

    // second level of group 1, sub field 3
    localparam logic [1:0] SEL_DLOAD = 2'd0;
    localparam logic [1:0] SEL_DIPSW = 2'd1;

endpackage

//--- logic/bcd_counter.sv
module bcd_counter #(
    parameter int DIGITS = 2,
    parameter bit WRAP   = 1'b1     // 0 holds at all nines
) (
    input  logic                  rst,
    input  logic                  clk,
    input  logic                  clr,
    input  logic                  up,
    output logic [DIGITS*4-1:0]   cnt
);
    import sys_info_pkg::*;

    bcd_digit_t      dig [DIGITS];
    logic [DIGITS:0] carry;         // carry[i] increments digit i
    logic            hold;

    // ripple carry, each digit passes on only when it sits at nine
    always_comb begin
        carry[0] = up;
        for (int i = 0; i < DIGITS; i++) begin
            carry[i+1] = carry[i] && (dig[i] == 4'd9);
        end
    end

    assign hold = carry[DIGITS] && !WRAP;  // saturating at top

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DIGITS; i++) begin
                dig[i] <= '0;
            end
        end else if (clr) begin     // clear wins over up
            for (int i = 0; i < DIGITS; i++) begin
                dig[i] <= '0;
            end
        end else if (!hold) begin
            for (int i = 0; i < DIGITS; i++) begin
                if (carry[i]) begin
                    dig[i] <= (dig[i] == 4'd9) ? 4'd0 : dig[i] + 4'd1;
                end
            end
        end
    end

    // flatten, digit 0 in the low nibble
    always_comb begin
        for (int i = 0; i < DIGITS; i++) begin
            cnt[i*4 +: 4] = dig[i];
        end
    end

endmodule

//--- logic/sample_rate_meter.sv
module sample_rate_meter #(
    parameter int MCLK_PER_MS = 48000   // clocks in one window
) (
    input  logic                    rst,
    input  logic                    clk,
    input  logic                    sample,
    output sys_info_pkg::rate_bcd_t srate
);
    import sys_info_pkg::*;

    localparam int WIN_W = $clog2(MCLK_PER_MS + 1);

    logic [WIN_W-1:0] win_cnt;      // 0 .. MCLK_PER_MS-1
    logic             win_end;
    logic             sample_r;     // sample as seen on clk
    logic             sample_l;
    logic             sample_up;
    rate_bcd_t        scnt;         // running count for this window

    assign win_end   = win_cnt == WIN_W'(MCLK_PER_MS - 1);
    assign sample_up = sample_r & ~sample_l;    // rising edge of registered sample

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            sample_r <= 1'b0;
            sample_l <= 1'b0;
            win_cnt  <= '0;
            srate    <= '0;
        end else begin
            sample_r <= sample;
            sample_l <= sample_r;
            if (win_end) begin
                win_cnt <= '0;
                srate   <= scnt;    // publish once per ms
            end else begin
                win_cnt <= win_cnt + 1'b1;
            end
        end
    end

    // an edge in the last window cycle is dropped by the clear
    bcd_counter #(
        .DIGITS ( 2         ),
        .WRAP   ( 1'b0      )       // stick at 99
    ) u_sample_cnt (
        .rst    ( rst       ),
        .clk    ( clk       ),
        .clr    ( win_end   ),
        .up     ( sample_up ),
        .cnt    ( scnt      )
    );

endmodule

//--- logic/bank_ready_stats.sv
module bank_ready_stats (
    input  logic                       rst,
    input  logic                       clk,
    input  sys_info_pkg::bank_rdy_t    rdy,
    input  logic                       frame_end,
    output sys_info_pkg::status_byte_t bank0_cnt,
    output sys_info_pkg::status_byte_t bank1_cnt,
    output sys_info_pkg::status_byte_t bank2_cnt,
    output sys_info_pkg::status_byte_t bank3_cnt
);
    import sys_info_pkg::*;

    status_byte_t cnt [NUM_BANKS];  // running, this frame
    status_byte_t lat [NUM_BANKS];  // last full frame

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_BANKS; i++) begin
                cnt[i] <= '0;
                lat[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_BANKS; i++) begin
                if (frame_end) begin
                    lat[i] <= cnt[i];
                    // a strobe on the boundary belongs to the new frame
                    cnt[i] <= status_byte_t'(rdy[i]);
                end else if (rdy[i] && cnt[i] != '1) begin
                    cnt[i] <= cnt[i] + 8'd1;   // saturates at 255
                end
            end
        end
    end

    assign bank0_cnt = lat[0];
    assign bank1_cnt = lat[1];
    assign bank2_cnt = lat[2];
    assign bank3_cnt = lat[3];

endmodule

//--- logic/status_select.sv
module status_select (
    input  logic                       rst,
    input  logic                       clk,
    input  logic                       run,
    input  logic                       dip_flip,
    input  logic                       game_led,
    input  logic                       lvbl,
    input  logic [6:0]                 core_mod,
    input  logic [5:0]                 snd_en,
    input  logic [5:0]                 snd_vu,
    input  logic [1:0]                 dial_x,
    input  logic [23:0]                dipsw,
    input  logic                       ioctl_ram,
    input  logic                       ioctl_rom,
    input  logic                       ioctl_cart,
    input  logic [8:0]                 mouse_dx,
    input  logic [8:0]                 mouse_dy,
    input  logic [7:0]                 mouse_f,
    input  sys_info_pkg::rate_bcd_t    srate,
    input  sys_info_pkg::status_byte_t bank0_cnt,
    input  sys_info_pkg::status_byte_t bank1_cnt,
    input  sys_info_pkg::status_byte_t bank2_cnt,
    input  sys_info_pkg::status_byte_t bank3_cnt,
    input  sys_info_pkg::status_addr_t st_addr,
    output logic                       frame_end,
    output sys_info_pkg::status_byte_t st_dout
);
    import sys_info_pkg::*;

    logic         lvbl_r, lvbl_l;   // two stage history of blanking
    logic         frame_up;         // registered vb exit strobe
    frame_bcd_t   frame_bcd;
    logic [1:0]   grp, sub, sel, idx;
    status_byte_t st_next;

    assign grp = st_addr[ADDR_GRP_HI:ADDR_GRP_LO];
    assign sub = st_addr[ADDR_SUB_HI:ADDR_SUB_LO];
    assign sel = st_addr[ADDR_SEL_HI:ADDR_SEL_LO];
    assign idx = st_addr[ADDR_IDX_HI:ADDR_IDX_LO];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            lvbl_r    <= 1'b0;
            lvbl_l    <= 1'b0;
            frame_up  <= 1'b0;
            frame_end <= 1'b0;
        end else begin
            lvbl_r    <= lvbl;
            lvbl_l    <= lvbl_r;
            frame_up  <= lvbl_r & ~lvbl_l & run;   // leaving blank, game running
            frame_end <= ~lvbl_r & lvbl_l;         // entering blank
        end
    end

    // address map
    always_comb begin
        st_next = '0;   // unmapped reads give zero
        case (grp)
            GRP_FRAME: case (idx)
                2'd0:    st_next = frame_bcd[15:8];
                2'd1:    st_next = frame_bcd[7:0];
                2'd2:    st_next = {4'd0, frame_bcd[19:16]};
                default: st_next = '0;
            endcase
            GRP_SYS: case (sub)
                2'd0: st_next = {2'd0, snd_vu};
                2'd1: st_next = {2'd0, snd_en};
                2'd2: st_next = srate;
                default: begin
                    if (sel == SEL_DLOAD) begin
                        st_next = {3'd0, ioctl_ram, 2'd0, ioctl_cart, ioctl_rom};
                    end else if (sel == SEL_DIPSW && idx != 2'd3) begin
                        st_next = dipsw[idx*8 +: 8];    // one dip byte
                    end
                end
            endcase
            GRP_BANK: case (idx)
                2'd0: st_next = bank0_cnt;
                2'd1: st_next = bank1_cnt;
                2'd2: st_next = bank2_cnt;
                2'd3: st_next = bank3_cnt;
            endcase
            GRP_IO: case (sub)
                2'd0: st_next = {core_mod[3:0], dial_x, game_led, dip_flip};
                2'd1: st_next = mouse_dx[8:1];   // drop lsb
                2'd2: st_next = mouse_dy[8:1];
                2'd3: st_next = mouse_f;
            endcase
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) st_dout <= '0;
        else     st_dout <= st_next;     // data one clock after address
    end

    bcd_counter #(
        .DIGITS ( 5         ),
        .WRAP   ( 1'b1      )            // 99999 rolls to 0
    ) u_frame_cnt (
        .rst    ( rst       ),
        .clk    ( clk       ),
        .clr    ( 1'b0      ),
        .up     ( frame_up  ),
        .cnt    ( frame_bcd )
    );

endmodule

//--- logic/sys_info_top.sv
module sys_info_top #(
    parameter int MCLK_PER_MS = 48000
) (
    input  logic                       rst,
    input  logic                       clk,
    input  logic                       run,
    input  logic                       dip_flip,
    input  logic                       game_led,
    input  logic                       lvbl,
    input  logic [6:0]                 core_mod,
    input  logic [5:0]                 snd_en,
    input  logic [5:0]                 snd_vu,
    input  logic [1:0]                 dial_x,
    input  logic [23:0]                dipsw,
    input  logic                       ioctl_ram,
    input  logic                       ioctl_rom,
    input  logic                       ioctl_cart,
    input  logic [8:0]                 mouse_dx,
    input  logic [8:0]                 mouse_dy,
    input  logic [7:0]                 mouse_f,
    input  logic                       sample,
    input  sys_info_pkg::bank_rdy_t    ba_rdy,
    input  sys_info_pkg::status_addr_t st_addr,
    output sys_info_pkg::status_byte_t st_dout
);
    import sys_info_pkg::*;

    rate_bcd_t    srate;            // latched each ms
    status_byte_t bank0_cnt, bank1_cnt, bank2_cnt, bank3_cnt;
    logic         frame_end;        // from control, once per frame

    // names line up with the control ports
    status_select u_select (.*);

    sample_rate_meter #(
        .MCLK_PER_MS ( MCLK_PER_MS )
    ) u_rate (
        .rst    ( rst    ),
        .clk    ( clk    ),
        .sample ( sample ),
        .srate  ( srate  )
    );

    bank_ready_stats u_stats (
        .rst       ( rst       ),
        .clk       ( clk       ),
        .rdy       ( ba_rdy    ),
        .frame_end ( frame_end ),
        .bank0_cnt ( bank0_cnt ),
        .bank1_cnt ( bank1_cnt ),
        .bank2_cnt ( bank2_cnt ),
        .bank3_cnt ( bank3_cnt )
    );

endmodule

//--- tb/sys_info_props.sv
module sys_info_props (
    input logic                       clk,
    input logic                       rst,
    input logic                       frame_end,
    input sys_info_pkg::rate_bcd_t    srate,
    input sys_info_pkg::frame_bcd_t   frame_bcd,
    input sys_info_pkg::status_byte_t st_dout
);
    timeunit 1ns;
    timeprecision 100ps;
    import sys_info_pkg::*;

    logic bcd_ok;   // every digit in 0..9

    always_comb begin
        bcd_ok = 1'b1;
        for (int i = 0; i < 5; i++) begin
            if (frame_bcd[i*4 +: 4] > 4'd9) bcd_ok = 1'b0;
        end
        for (int i = 0; i < 2; i++) begin
            if (srate[i*4 +: 4] > 4'd9) bcd_ok = 1'b0;
        end
    end

    // first byte registered after release reads zero
    a_dout_after_rst: assert property (@(posedge clk) $fell(rst) |=> st_dout == '0)
        else $error("st_dout not zero in the first cycle after reset");

    a_bcd_digits: assert property (@(posedge clk) disable iff (rst) bcd_ok)
        else $error("frame or rate digit above nine");

    a_frame_end_pulse: assert property (@(posedge clk) disable iff (rst)
        frame_end |=> !frame_end)
        else $error("frame_end held for two cycles");

endmodule

bind sys_info_top sys_info_props props_inst (
    .clk       ( clk                ),
    .rst       ( rst                ),
    .frame_end ( frame_end          ),
    .srate     ( srate              ),
    .frame_bcd ( u_select.frame_bcd ),
    .st_dout   ( st_dout            )
);

//--- tb/sys_info_tb.sv
module sys_info_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import sys_info_pkg::*;

    localparam int WIN = 100;       // clocks per rate window

    logic         clk = 1'b0;
    logic         rst;
    logic         run;
    logic         dip_flip;
    logic         game_led;
    logic         lvbl;             // high while the line is active
    logic [6:0]   core_mod;
    logic [5:0]   snd_en;
    logic [5:0]   snd_vu;
    logic [1:0]   dial_x;
    logic [23:0]  dipsw;
    logic         ioctl_ram;
    logic         ioctl_rom;
    logic         ioctl_cart;
    logic [8:0]   mouse_dx;
    logic [8:0]   mouse_dy;
    logic [7:0]   mouse_f;
    logic         sample = 1'b0;    // owned by the sample driver below
    bank_rdy_t    ba_rdy;
    status_addr_t st_addr;
    status_byte_t st_dout;

    integer seed = 95808;
    int     checks = 0;
    int     errors = 0;
    int     test_err = 0;           // errors at start of current test
    int     m_frame = 0;            // model frame count in binary
    int     m_cur [NUM_BANKS];      // model pulses in the running frame
    int     m_bank [NUM_BANKS];     // model pulses of the last frame
    int     samp_period = 0;        // 0 keeps sample low
    int     samp_ph = 0;
    int     win_pos;                // model window position
    int     edge_cnt;
    int     m_rate;
    int     win_done;               // windows finished since reset
    logic   samp_d1;
    logic   samp_d2;

    always #2 clk = ~clk;

    sys_info_top #(.MCLK_PER_MS(WIN)) sys_info_top_inst (.*);

    // one high clock every samp_period clocks
    always @(negedge clk) begin
        if (samp_period == 0) begin
            sample  <= 1'b0;
            samp_ph <= 0;
        end else begin
            sample  <= (samp_ph == 0);
            samp_ph <= (samp_ph + 1) % samp_period;
        end
    end

    // rate model sees edges two clocks late and loses the one on the last window clock
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            win_pos  = 0;
            edge_cnt = 0;
            m_rate   = 0;
            win_done = 0;
            samp_d1  = 1'b0;
            samp_d2  = 1'b0;
        end else begin
            if (win_pos == WIN - 1) begin
                m_rate   = edge_cnt;    // publish and restart
                edge_cnt = 0;
                win_pos  = 0;
                win_done++;
            end else begin
                if (samp_d1 && !samp_d2 && edge_cnt < 99) edge_cnt++;
                win_pos++;
            end
            samp_d2 = samp_d1;
            samp_d1 = sample;
        end
    end

    function automatic frame_bcd_t to_bcd(input int value);
        frame_bcd_t b;
        int         v;
        v = value;
        for (int i = 0; i < 5; i++) begin
            b[i*4 +: 4] = 4'(v % 10);
            v = v / 10;
        end
        return b;
    endfunction

    // address map applied to the driven inputs and the model counters
    function automatic status_byte_t expected_byte(input status_addr_t a);
        frame_bcd_t fb;
        frame_bcd_t rb;
        fb = to_bcd(m_frame);
        rb = to_bcd(m_rate);
        case (a[7:6])
            2'd0: case (a[1:0])
                2'd0:    return fb[15:8];
                2'd1:    return fb[7:0];
                2'd2:    return {4'd0, fb[19:16]};
                default: return 8'd0;
            endcase
            2'd1: case (a[5:4])
                2'd0: return {2'd0, snd_vu};
                2'd1: return {2'd0, snd_en};
                2'd2: return rb[7:0];
                default: begin
                    if (a[3:2] == 2'd0) return {3'd0, ioctl_ram, 2'd0, ioctl_cart, ioctl_rom};
                    if (a[3:2] == 2'd1 && a[1:0] != 2'd3) return dipsw[a[1:0]*8 +: 8];
                    return 8'd0;
                end
            endcase
            2'd2: return 8'(m_bank[a[1:0]]);
            default: case (a[5:4])
                2'd0:    return {core_mod[3:0], dial_x, game_led, dip_flip};
                2'd1:    return mouse_dx[8:1];
                2'd2:    return mouse_dy[8:1];
                default: return mouse_f;
            endcase
        endcase
    endfunction

    // called just after a falling edge and returns after the next one
    task automatic check_addr(input status_addr_t a);
        status_byte_t exp;
        st_addr = a;
        exp = expected_byte(a);     // state the DUT sees at the coming posedge
        @(negedge clk);
        checks++;
        if (st_dout !== exp) begin
            $display("FAILED time=%0t st_dout addr=%02h got=%02h expected=%02h",
                     $time, a, st_dout, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        $display("test %0s done, %0d errors", name, errors - test_err);
        test_err = errors;
    endtask

    // blank for lo clocks, then active for hi clocks
    task automatic frame_pulse(input int lo, input int hi);
        lvbl = 1'b0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            m_bank[b] = m_cur[b];   // frame closes on blank entry
            m_cur[b]  = 0;
        end
        repeat (lo) @(negedge clk);
        lvbl = 1'b1;
        if (run) m_frame = (m_frame + 1) % 100000;
        repeat (hi) @(negedge clk);
    endtask

    task automatic wait_windows(input int n);
        int target;
        int t;
        target = win_done + n;
        t = 0;
        while (win_done < target && t < n * WIN + 10) begin
            @(negedge clk);
            t++;
        end
        if (win_done < target) begin
            $display("timeout waiting for the rate window to close");
            errors++;
        end
    endtask

    task automatic randomize_inputs();
        logic [31:0] r;
        r = $random(seed);
        core_mod = r[6:0];
        dial_x   = r[8:7];
        game_led = r[9];
        dip_flip = r[10];
        ioctl_ram  = r[11];
        ioctl_rom  = r[12];
        ioctl_cart = r[13];
        snd_en   = r[19:14];
        snd_vu   = r[25:20];
        r = $random(seed);
        dipsw    = r[23:0];
        mouse_f  = r[31:24];
        r = $random(seed);
        mouse_dx = r[8:0];
        mouse_dy = r[17:9];
    endtask

    initial begin
        rst = 1'b1;
        run = 1'b0;
        lvbl = 1'b1;
        {dip_flip, game_led, ioctl_ram, ioctl_rom, ioctl_cart} = '0;
        {core_mod, snd_en, snd_vu, dial_x, dipsw} = '0;
        {mouse_dx, mouse_dy, mouse_f} = '0;
        ba_rdy = '0;
        st_addr = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            m_cur[b]  = 0;
            m_bank[b] = 0;
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;

        // frame, rate and bank bytes straight out of reset
        for (int a = 0; a < 4; a++) check_addr(8'(a));
        check_addr(8'h60);
        for (int a = 0; a < 4; a++) check_addr(8'h80 + 8'(a));
        end_test("1 reset values");

        for (int n = 0; n < 40; n++) begin
            randomize_inputs();
            for (int a = 0; a < 256; a++) check_addr(8'(a));   // whole map
        end
        end_test("2 static map");

        run = 1'b1;
        repeat (12) frame_pulse(2, 2);
        run = 1'b0;
        repeat (3) frame_pulse(2, 2);   // game halted so no count
        run = 1'b1;
        repeat (4) @(negedge clk);
        for (int a = 0; a < 4; a++) check_addr(8'(a));
        repeat (99999 - m_frame) frame_pulse(1, 1);   // fast run up to 99999
        repeat (4) @(negedge clk);
        for (int a = 0; a < 4; a++) check_addr(8'(a));
        frame_pulse(1, 4);              // rolls over
        for (int a = 0; a < 4; a++) check_addr(8'(a));
        end_test("3 frame counter");

        samp_period = 4;
        wait_windows(2);
        check_addr(8'h60);
        samp_period = 2;                // fastest edge rate the meter can see
        wait_windows(2);
        check_addr(8'h60);
        samp_period = 0;
        wait_windows(2);
        check_addr(8'h60);
        end_test("4 sample rate");

        for (int i = 0; i < 300; i++) begin
            ba_rdy = {(i % 10 == 0), 1'b1, (i < 17), (i < 5)};
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (ba_rdy[b] && m_cur[b] < 255) m_cur[b]++;
            end
            @(negedge clk);
        end
        ba_rdy = '0;
        frame_pulse(4, 4);
        for (int a = 0; a < 4; a++) check_addr(8'h80 + 8'(a));
        frame_pulse(4, 4);              // quiet frame
        for (int a = 0; a < 4; a++) check_addr(8'h80 + 8'(a));
        end_test("5 bank stats");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
logic/sys_info_pkg.sv
logic/bcd_counter.sv
logic/sample_rate_meter.sv
logic/bank_ready_stats.sv
logic/status_select.sv
logic/sys_info_top.sv
tb/sys_info_props.sv
tb/sys_info_tb.sv
